//--- csr_access_unit.sv
`timescale 1ns/10ps

// Four-phase req/ack front end of the CSR subsystem.
// One request gives exactly one write strobe, however long
// the requester keeps i_req high.
module csr_access_unit
    import csr_pkg::*;
(
    // Control
    input  logic      i_clock,
    input  logic      i_reset,

    // Requester side
    input  logic      i_req,
    input  csr_req_t  i_req_data,                  // Sampled only when leaving idle
    output logic      o_ack,
    output csr_resp_t o_resp,                      // Valid while o_ack is high

    // Register file side
    output csr_req_t  o_file_req,
    output logic      o_wr_strobe,
    input  csr_resp_t i_file_resp
);

    csr_acc_state_e state_q;
    csr_acc_state_e state_d;

    csr_req_t  req_q;                              // Latched request
    csr_resp_t resp_q;                             // Old value captured before the write

    // ------------------------------------------------------------------
    // Handshake FSM
    // ------------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            ACC_IDLE : if (i_req) state_d = ACC_EXEC;
            ACC_EXEC : state_d = ACC_ACK;          // Single access cycle
            ACC_ACK  : if (!i_req) state_d = ACC_IDLE;
            default  : state_d = ACC_IDLE;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset)
            state_q <= ACC_IDLE;
        else
            state_q <= state_d;
    end

    // ------------------------------------------------------------------
    // Request and response holding registers
    // ------------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (state_q == ACC_IDLE && i_req)
            req_q <= i_req_data;                   // Requester free to change data later
        if (state_q == ACC_EXEC)
            resp_q <= i_file_resp;                 // Same edge as the register write
    end

    assign o_file_req  = req_q;
    assign o_wr_strobe = (state_q == ACC_EXEC);   // High for exactly one cycle
    assign o_ack       = (state_q == ACC_ACK);
    assign o_resp      = resp_q;

endmodule

//--- csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// ----------------------------------------------------------------------
// Machine-mode CSR subsystem, RV32 build switches
// ----------------------------------------------------------------------

`define CSR_XLEN            32              // Register word width

// Extension switches, 1 enables the extension
`define CSR_EXT_C           1               // Compressed instructions
`define CSR_EXT_M           1               // Integer multiply/divide

// misa: MXL=1 (RV32) in bits 31:30, I base always present
`define CSR_MISA_VALUE      ((32'd1 << 30) | (32'd1 << 8) | \
                             (32'(`CSR_EXT_C) << 2) | (32'(`CSR_EXT_M) << 12))

// mstatus keeps MIE (bit 3) and MPIE (bit 7) writable
`define CSR_MSTATUS_WMASK   32'h0000_0088
`define CSR_MSTATUS_RESET   32'h0000_1800   // MPP = 3, machine mode only

// mie keeps MSIE (3), MTIE (7) and MEIE (11)
`define CSR_MIE_WMASK       32'h0000_0888

// mtvec bit 1 is reserved in the mode field
`define CSR_MTVEC_WMASK     32'hFFFF_FFFD

// mepc aligns to 2 bytes with C, to 4 bytes without
`define CSR_MEPC_WMASK      ((`CSR_EXT_C != 0) ? 32'hFFFF_FFFE : 32'hFFFF_FFFC)

`endif

//--- csr_counters.sv
`timescale 1ns/10ps

// Free-running cycle and retired-instruction counters.
// Kept apart from the register file since they advance
// regardless of any CSR access.
module csr_counters
    import csr_pkg::*;
(
    // Control
    input  logic       i_clock,
    input  logic       i_reset,                    // Synchronous, active high

    // Events
    input  logic       i_retire,                   // One pulse per retired instruction

    // Counter values
    output csr_count_t o_cycle,
    output csr_count_t o_instret
);

    csr_count_t cycle_q;                           // Clocks since reset
    csr_count_t instret_q;                         // Retire pulses since reset

    // ------------------------------------------------------------------
    // Cycle counter
    // ------------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset)
            cycle_q <= '0;
        else
            cycle_q <= cycle_q + csr_count_t'(1);  // Every edge, wraps at 2^64
    end

    // ------------------------------------------------------------------
    // Retired-instruction counter
    // ------------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset)
            instret_q <= '0;
        else if (i_retire)
            instret_q <= instret_q + csr_count_t'(1);
    end

    // Full 64-bit values, the register file splits them in halves
    assign o_cycle   = cycle_q;
    assign o_instret = instret_q;

endmodule

//--- csr_file.sv
`timescale 1ns/10ps

`include "csr_config.svh"

// Machine-mode CSR storage with read-then-modify access.
// Read side is purely combinational from the latched request,
// the write lands on the strobe edge.
module csr_file
    import csr_pkg::*;
(
    // Control
    input  logic       i_clock,
    input  logic       i_reset,

    // Access from the handshake unit
    input  csr_req_t   i_req,                      // Held stable during the access
    input  logic       i_wr_strobe,                // One cycle, commits the write

    // Counter sources
    input  csr_count_t i_cycle,
    input  csr_count_t i_instret,
    input  csr_count_t i_time,                     // Supplied from outside

    // Result
    output csr_resp_t  o_resp
);

    // Machine information and trap setup
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MISA     = 12'h301;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;

    // Trap handling
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;

    // Read-only counters, low and high halves
    localparam csr_addr_t CSR_CYCLE    = 12'hC00;
    localparam csr_addr_t CSR_TIME     = 12'hC01;
    localparam csr_addr_t CSR_INSTRET  = 12'hC02;
    localparam csr_addr_t CSR_CYCLEH   = 12'hC80;
    localparam csr_addr_t CSR_TIMEH    = 12'hC81;
    localparam csr_addr_t CSR_INSTRETH = 12'hC82;

    localparam csr_data_t MISA = `CSR_MISA_VALUE;  // Hard-wired, writes ignored

    csr_data_t mstatus_q;
    csr_data_t mie_q;
    csr_data_t mtvec_q;
    csr_data_t mscratch_q;
    csr_data_t mepc_q;
    csr_data_t mcause_q;

    csr_data_t old_value;                          // Current contents at i_req.addr
    csr_data_t new_value;                          // Unmasked result of the operation
    logic      known;                              // Address is implemented
    logic      read_only;                          // Bits 11:10 both set
    logic      illegal;
    logic      wr_en;

    // ------------------------------------------------------------------
    // Address decode and read multiplexer
    // ------------------------------------------------------------------

    always_comb begin
        known     = 1'b1;
        old_value = '0;
        case (i_req.addr)
            CSR_MSTATUS  : old_value = mstatus_q;
            CSR_MISA     : old_value = MISA;
            CSR_MIE      : old_value = mie_q;
            CSR_MTVEC    : old_value = mtvec_q;
            CSR_MSCRATCH : old_value = mscratch_q;
            CSR_MEPC     : old_value = mepc_q;
            CSR_MCAUSE   : old_value = mcause_q;
            CSR_CYCLE    : old_value = i_cycle[`CSR_XLEN-1:0];
            CSR_TIME     : old_value = i_time[`CSR_XLEN-1:0];
            CSR_INSTRET  : old_value = i_instret[`CSR_XLEN-1:0];
            CSR_CYCLEH   : old_value = i_cycle[2*`CSR_XLEN-1:`CSR_XLEN];
            CSR_TIMEH    : old_value = i_time[2*`CSR_XLEN-1:`CSR_XLEN];
            CSR_INSTRETH : old_value = i_instret[2*`CSR_XLEN-1:`CSR_XLEN];
            default      : known     = 1'b0;       // Reads as zero, flagged below
        endcase
    end

    // Legality, a plain read of any implemented address is fine
    assign read_only = (i_req.addr[11:10] == 2'b11);
    assign illegal   = !known || ((i_req.op != CSR_OP_READ) && read_only);

    assign o_resp.rdata   = old_value;
    assign o_resp.illegal = illegal;

    // ------------------------------------------------------------------
    // Read-modify-write
    // ------------------------------------------------------------------

    always_comb begin
        case (i_req.op)
            CSR_OP_WRITE : new_value = i_req.operand;
            CSR_OP_SET   : new_value = old_value | i_req.operand;
            CSR_OP_CLEAR : new_value = old_value & ~i_req.operand;
            default      : new_value = old_value;  // Read leaves it alone
        endcase
    end

    // Only legal modifying operations commit
    assign wr_en = i_wr_strobe && !illegal && (i_req.op != CSR_OP_READ);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            mstatus_q  <= `CSR_MSTATUS_RESET;      // MPP reads as machine mode
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end
        else if (wr_en) begin
            case (i_req.addr)
                // Fixed fields keep their reset pattern
                CSR_MSTATUS  : mstatus_q  <= (new_value & `CSR_MSTATUS_WMASK) |
                                             (`CSR_MSTATUS_RESET & ~`CSR_MSTATUS_WMASK);
                CSR_MIE      : mie_q      <= new_value & `CSR_MIE_WMASK;
                CSR_MTVEC    : mtvec_q    <= new_value & `CSR_MTVEC_WMASK;
                CSR_MSCRATCH : mscratch_q <= new_value;
                CSR_MEPC     : mepc_q     <= new_value & `CSR_MEPC_WMASK;
                CSR_MCAUSE   : mcause_q   <= new_value;
                default      : ;                   // misa is WARL, write dropped
            endcase
        end
    end

endmodule

//--- csr_pkg.sv
`include "csr_config.svh"

// ----------------------------------------------------------------------
// Shared types of the CSR subsystem
// ----------------------------------------------------------------------

package csr_pkg;

    typedef logic [`CSR_XLEN-1:0]   csr_data_t;    // One register word
    typedef logic [11:0]            csr_addr_t;    // CSR address space
    typedef logic [2*`CSR_XLEN-1:0] csr_count_t;   // Full 64-bit counter

    // Access operation, same meaning as CSRRW/CSRRS/CSRRC plus plain read
    typedef enum logic [1:0] {
        CSR_OP_READ  = 2'b00,                      // No modification
        CSR_OP_WRITE = 2'b01,                      // new = operand
        CSR_OP_SET   = 2'b10,                      // new = old | operand
        CSR_OP_CLEAR = 2'b11                       // new = old & ~operand
    } csr_op_e;

    // Request word, 12 + 2 + 32 = 46 bits
    typedef struct packed {
        csr_addr_t addr;                           // Target register
        csr_op_e   op;                             // What to do with it
        csr_data_t operand;                        // Write data or bit mask
    } csr_req_t;

    // Response word, 32 + 1 = 33 bits
    typedef struct packed {
        csr_data_t rdata;                          // Value before the write
        logic      illegal;                        // Unknown or read-only violation
    } csr_resp_t;

    // Handshake FSM of the access unit
    typedef enum logic [1:0] {
        ACC_IDLE,                                  // Waiting for i_req
        ACC_EXEC,                                  // Request latched, strobe cycle
        ACC_ACK                                    // Ack held until i_req drops
    } csr_acc_state_e;

endpackage

//--- csr_top.sv
`timescale 1ns/10ps

// Top of the machine-mode CSR subsystem.
// Ack follows two edges after the request edge, then drops
// one edge after the request goes low.
module csr_top
    import csr_pkg::*;
(
    // Control
    input  logic       i_clock,
    input  logic       i_reset,

    // Four-phase access port
    input  logic       i_req,
    input  csr_req_t   i_req_data,
    output logic       o_ack,
    output csr_resp_t  o_resp,

    // Core events and external time
    input  logic       i_retire,
    input  csr_count_t i_time
);

    csr_req_t   file_req;                          // Latched request into the file
    logic       wr_strobe;
    csr_resp_t  file_resp;                         // Combinational old value and flag
    csr_count_t cycle;
    csr_count_t instret;

    csr_access_unit u_access (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_req       (i_req),
        .i_req_data  (i_req_data),
        .o_ack       (o_ack),
        .o_resp      (o_resp),
        .o_file_req  (file_req),
        .o_wr_strobe (wr_strobe),
        .i_file_resp (file_resp)
    );

    csr_file u_file (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_req       (file_req),
        .i_wr_strobe (wr_strobe),
        .i_cycle     (cycle),
        .i_instret   (instret),
        .i_time      (i_time),
        .o_resp      (file_resp)
    );

    csr_counters u_counters (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_retire    (i_retire),
        .o_cycle     (cycle),
        .o_instret   (instret)
    );

endmodule

//--- flist.f
+incdir+.
csr_pkg.sv
csr_counters.sv
csr_file.sv
csr_access_unit.sv
csr_top.sv
tb_csr_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the CSR testbench with Verilator and run it.
# The exit status is the simulator's, non-zero on any failure.
cd "$(dirname "$0")" \
    && verilator --binary --timing -f flist.f --top-module tb_csr_top -o tb_csr_top \
    && ./obj_dir/tb_csr_top \
    || { echo "simulation failed"; exit 1; }

//--- tb_csr_model.svh
`ifndef TB_CSR_MODEL_SVH
`define TB_CSR_MODEL_SVH

// ----------------------------------------------------------------------
// Reference model of the machine-mode CSR subsystem
// ----------------------------------------------------------------------

localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
localparam csr_addr_t ADDR_MISA     = 12'h301;
localparam csr_addr_t ADDR_MIE      = 12'h304;
localparam csr_addr_t ADDR_MTVEC    = 12'h305;
localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
localparam csr_addr_t ADDR_MEPC     = 12'h341;
localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
localparam csr_addr_t ADDR_CYCLE    = 12'hC00;
localparam csr_addr_t ADDR_TIME     = 12'hC01;
localparam csr_addr_t ADDR_INSTRET  = 12'hC02;
localparam csr_addr_t ADDR_CYCLEH   = 12'hC80;
localparam csr_addr_t ADDR_TIMEH    = 12'hC81;
localparam csr_addr_t ADDR_INSTRETH = 12'hC82;

localparam logic [31:0] RNG_SEED = 32'hec47c7ff;

logic [31:0] rng_state = RNG_SEED;                 // Stimulus generator state

csr_data_t m_mstatus;                              // Model copies of the registers
csr_data_t m_mie;
csr_data_t m_mtvec;
csr_data_t m_mscratch;
csr_data_t m_mepc;
csr_data_t m_mcause;

// 32-bit xorshift, shifts 13/17/5
function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic logic [31:0] rand_word();
    rng_state = xorshift(rng_state);
    return rng_state;
endfunction

// misa built bit by bit from the extension letters
function automatic csr_data_t misa_expected();
    csr_data_t v;
    v = '0;
    v[31:30] = 2'b01;                              // MXL = RV32
    v[8]     = 1'b1;                               // I
    v[2]     = (`CSR_EXT_C != 0);                  // C
    v[12]    = (`CSR_EXT_M != 0);                  // M
    return v;
endfunction

// Halfword alignment only with C
function automatic csr_data_t mepc_mask();
    csr_data_t m;
    m    = '1;
    m[0] = 1'b0;
    if (`CSR_EXT_C == 0)
        m[1] = 1'b0;
    return m;
endfunction

function automatic void model_reset();
    m_mstatus  = `CSR_MSTATUS_RESET;
    m_mie      = '0;
    m_mtvec    = '0;
    m_mscratch = '0;
    m_mepc     = '0;
    m_mcause   = '0;
endfunction

function automatic logic is_known(input csr_addr_t addr);
    case (addr)
        ADDR_MSTATUS, ADDR_MISA, ADDR_MIE, ADDR_MTVEC,
        ADDR_MSCRATCH, ADDR_MEPC, ADDR_MCAUSE,
        ADDR_CYCLE, ADDR_TIME, ADDR_INSTRET,
        ADDR_CYCLEH, ADDR_TIMEH, ADDR_INSTRETH : return 1'b1;
        default                                : return 1'b0;
    endcase
endfunction

function automatic logic expect_illegal(input csr_addr_t addr, input csr_op_e op);
    return !is_known(addr) || ((op != CSR_OP_READ) && (addr[11:10] == 2'b11));
endfunction

// Storage registers only, counters are checked separately
function automatic csr_data_t model_value(input csr_addr_t addr);
    csr_data_t v;
    case (addr)
        ADDR_MISA     : v = misa_expected();
        ADDR_MSTATUS  : v = m_mstatus;
        ADDR_MIE      : v = m_mie;
        ADDR_MTVEC    : v = m_mtvec;
        ADDR_MSCRATCH : v = m_mscratch;
        ADDR_MEPC     : v = m_mepc;
        ADDR_MCAUSE   : v = m_mcause;
        default       : v = '0;
    endcase
    return v;
endfunction

function automatic void model_apply(input csr_addr_t addr, input csr_op_e op,
                                    input csr_data_t operand);
    csr_data_t old_v;
    csr_data_t new_v;
    if (op == CSR_OP_READ || expect_illegal(addr, op))
        return;                                    // Nothing changes
    old_v = model_value(addr);
    case (op)
        CSR_OP_WRITE : new_v = operand;
        CSR_OP_SET   : new_v = old_v | operand;
        default      : new_v = old_v & ~operand;
    endcase
    case (addr)
        ADDR_MSTATUS  : m_mstatus = (new_v & `CSR_MSTATUS_WMASK) |
                                    (`CSR_MSTATUS_RESET & ~`CSR_MSTATUS_WMASK);
        ADDR_MIE      : m_mie      = new_v & `CSR_MIE_WMASK;
        ADDR_MTVEC    : m_mtvec    = new_v & 32'hFFFF_FFFD;  // Bit 1 reads zero
        ADDR_MSCRATCH : m_mscratch = new_v;
        ADDR_MEPC     : m_mepc     = new_v & mepc_mask();
        ADDR_MCAUSE   : m_mcause   = new_v;
        default       : ;                          // misa stays constant
    endcase
endfunction

// ----------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------

task automatic check_data(input string name, input csr_data_t got, input csr_data_t exp);
    if (got !== exp) begin
        $display("Fail %s: got %h expected %h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_illegal(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("Fail %s: got %h expected %h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_count(input string name, input csr_count_t got, input csr_count_t exp);
    if (got !== exp) begin
        $display("Fail %s: got %h expected %h", name, got, exp);
        abort_run();
    end
endtask

`endif

//--- tb_csr_top.sv
`timescale 1ns/10ps

`include "csr_config.svh"

module tb_csr_top
    import csr_pkg::*;
();

    localparam int CLK_PERIOD     = 100;
    localparam int N_RANDOM       = 300;
    localparam int N_ILLEGAL      = 16;            // Each followed by 7 readbacks
    localparam int N_COUNT        = 4;             // 4 counter reads per round
    localparam int N_BACKPRESSURE = 20;            // Set plus readback
    localparam int NUM_TRANS      = 7 + N_RANDOM + N_ILLEGAL * 8 + N_COUNT * 4 + 3 +
                                    N_BACKPRESSURE * 2;
    localparam int WATCHDOG_NS    = (NUM_TRANS * 10 + 50) * CLK_PERIOD;

    logic       clock;
    logic       reset;
    logic       req;
    csr_req_t   req_data;
    logic       ack;
    csr_resp_t  resp;
    logic       retire;
    csr_count_t time_value;

    logic [31:0] retire_rng;                       // Separate stream for retire pulses
    csr_count_t  retire_count;                     // Pulses seen by the counter
    csr_count_t  retire_snap;                      // Count during the last EXEC cycle

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    `include "tb_csr_model.svh"

    localparam csr_addr_t REG_LIST [7] = '{ADDR_MISA, ADDR_MSTATUS, ADDR_MIE, ADDR_MTVEC,
                                           ADDR_MSCRATCH, ADDR_MEPC, ADDR_MCAUSE};
    localparam csr_addr_t BAD_LIST [8] = '{12'h000, 12'h001, 12'h306, 12'h343,
                                           12'hF11, 12'hC03, 12'h7C0, 12'hB00};
    localparam csr_addr_t RO_LIST  [6] = '{ADDR_CYCLE, ADDR_TIME, ADDR_INSTRET,
                                           ADDR_CYCLEH, ADDR_TIMEH, ADDR_INSTRETH};

    csr_top UUT (
        .i_clock    (clock),
        .i_reset    (reset),
        .i_req      (req),
        .i_req_data (req_data),
        .o_ack      (ack),
        .o_resp     (resp),
        .i_retire   (retire),
        .i_time     (time_value)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // Watchdog sized from the transaction count
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: no acknowledge");
        abort_run();
    end

    // Random retire pulse, new value every falling edge
    always @(negedge clock) begin
        retire_rng = xorshift(retire_rng);
        retire     = retire_rng[3];
    end

    always @(posedge clock) begin
        if (reset)
            retire_count <= '0;
        else if (retire)
            retire_count <= retire_count + csr_count_t'(1);
    end

    // ------------------------------------------------------------------
    // One four-phase transaction, hold = extra cycles i_req stays high
    // ------------------------------------------------------------------

    task automatic do_access(input csr_addr_t addr, input csr_op_e op,
                             input csr_data_t operand, input int hold,
                             output csr_resp_t result);
        csr_req_t    r;
        logic [63:0] noise;
        r.addr    = addr;
        r.op      = op;
        r.operand = operand;
        @(negedge clock);
        req      = 1'b1;
        req_data = r;
        @(negedge clock);
        retire_snap = retire_count;                // DUT is in its EXEC cycle now
        while (!ack)
            @(negedge clock);
        result   = resp;
        noise    = {rand_word(), rand_word()};
        req_data = noise[45:0];                    // Latched copy must be used from here
        repeat (hold) begin
            @(negedge clock);
            if (!ack) begin
                $display("acknowledge dropped while the request was still high");
                abort_run();
            end
            check_data("o_resp.rdata (held)", resp.rdata, result.rdata);
            check_illegal("o_resp.illegal (held)", resp.illegal, result.illegal);
        end
        req = 1'b0;
        while (ack)
            @(negedge clock);
    endtask

    // Reads all storage registers and compares with the model
    task automatic verify_registers();
        csr_resp_t rsp;
        for (int i = 0; i < 7; i++) begin
            do_access(REG_LIST[i], CSR_OP_READ, '0, 0, rsp);
            check_illegal($sformatf("o_resp.illegal @%h", REG_LIST[i]), rsp.illegal, 1'b0);
            check_data($sformatf("o_resp.rdata @%h", REG_LIST[i]), rsp.rdata,
                       model_value(REG_LIST[i]));
        end
    endtask

    initial begin
        csr_resp_t   rsp;
        logic [31:0] r;
        csr_addr_t   a;
        csr_op_e     op;
        csr_data_t   opnd;
        csr_data_t   hi;
        csr_data_t   prev;
        csr_count_t  snap_hi;
        reset      = 1'b1;
        req        = 1'b0;
        req_data   = '0;
        retire     = 1'b0;
        time_value = '0;
        retire_rng = ~RNG_SEED;
        model_reset();
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        verify_registers();                        // Reset values and misa

        // ------------------------------------------------------------------
        // Random traffic, mostly implemented registers
        // ------------------------------------------------------------------
        for (int n = 0; n < N_RANDOM; n++) begin
            r = rand_word();
            if (r[2:0] == 3'd0)
                a = BAD_LIST[r[5:3]];
            else
                a = REG_LIST[int'(r[15:8]) % 7];
            op   = csr_op_e'(r[17:16]);
            opnd = rand_word();
            do_access(a, op, opnd, 0, rsp);
            check_illegal($sformatf("o_resp.illegal @%h", a), rsp.illegal,
                          expect_illegal(a, op));
            if (!expect_illegal(a, op))
                check_data($sformatf("o_resp.rdata @%h", a), rsp.rdata, model_value(a));
            model_apply(a, op, opnd);
        end

        // Illegal accesses must not disturb any register
        for (int n = 0; n < N_ILLEGAL; n++) begin
            r = rand_word();
            if (r[0]) begin
                a  = BAD_LIST[r[3:1]];
                op = csr_op_e'(r[5:4]);            // Even a read is illegal here
            end
            else begin
                a  = RO_LIST[int'(r[11:4]) % 6];
                op = (r[13:12] == 2'b00) ? CSR_OP_WRITE : csr_op_e'(r[13:12]);
            end
            do_access(a, op, rand_word(), 0, rsp);
            check_illegal($sformatf("o_resp.illegal @%h", a), rsp.illegal, 1'b1);
            verify_registers();
        end

        // ------------------------------------------------------------------
        // instret against the pulse count, time against the input
        // ------------------------------------------------------------------
        for (int n = 0; n < N_COUNT; n++) begin
            repeat (int'(rand_word() % 32'd5)) @(negedge clock);
            do_access(ADDR_INSTRETH, CSR_OP_READ, '0, 0, rsp);
            check_illegal("o_resp.illegal instreth", rsp.illegal, 1'b0);
            hi      = rsp.rdata;
            snap_hi = retire_snap;
            do_access(ADDR_INSTRET, CSR_OP_READ, '0, 0, rsp);
            check_illegal("o_resp.illegal instret", rsp.illegal, 1'b0);
            check_count("instret", {hi, rsp.rdata}, {snap_hi[63:32], retire_snap[31:0]});
            time_value = {rand_word(), rand_word()};   // Constant for both reads
            do_access(ADDR_TIMEH, CSR_OP_READ, '0, 0, rsp);
            hi = rsp.rdata;
            do_access(ADDR_TIME, CSR_OP_READ, '0, 0, rsp);
            check_count("time", {hi, rsp.rdata}, time_value);
        end

        // Cycle counter strictly increasing, at least one transaction apart
        do_access(ADDR_CYCLE, CSR_OP_READ, '0, 0, rsp);
        prev = rsp.rdata;
        for (int n = 0; n < 2; n++) begin
            do_access(ADDR_CYCLE, CSR_OP_READ, '0, 0, rsp);
            if (rsp.rdata <= prev || (rsp.rdata - prev) < 32'd3) begin
                $display("Fail cycle: got %h after %h, step below 3", rsp.rdata, prev);
                abort_run();
            end
            prev = rsp.rdata;
        end

        // ------------------------------------------------------------------
        // Back-pressure, request held high after ack
        // ------------------------------------------------------------------
        for (int n = 0; n < N_BACKPRESSURE; n++) begin
            r    = rand_word();
            a    = REG_LIST[int'(r[7:0]) % 6 + 1]; // Skip misa
            opnd = rand_word();
            do_access(a, CSR_OP_SET, opnd, int'(r[10:8]), rsp);
            check_data($sformatf("o_resp.rdata @%h", a), rsp.rdata, model_value(a));
            model_apply(a, CSR_OP_SET, opnd);
            do_access(a, CSR_OP_READ, '0, 0, rsp);
            check_data($sformatf("o_resp.rdata @%h after set", a), rsp.rdata,
                       model_value(a));
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule
